/* Bender.yml */
package:
  name: bytepipe_regs

sources:
  - include_dirs:
      - logic
    files:
      - logic/bp_pkg.sv
      - logic/pkt_fifo.sv
      - logic/sample_engine.sv
      - logic/bp_reg.sv
      - logic/bp_top.sv
  - target: test
    files:
      - bench/bp_tb.sv

/* bench/bp_tb.sv */
`timescale 1ns/10ps
`default_nettype none

// Testbench for bp_top that steps through the records of bench/bp_testdata.hex
module bp_tb;

  localparam int MAX_REC    = 128;
  localparam int REC_CYCLES = 4000; // Watchdog budget per record
  localparam int FLUSH_LEN  = 20;   // Burst length that clears all stale FIFO bytes

  logic        i_clk;
  logic        i_rst_n;
  logic [7:0]  i_bp_data;
  logic        i_bp_valid;
  wire         o_bp_ready;
  wire  [7:0]  o_bp_data;
  wire         o_bp_valid;
  logic        i_bp_ready;
  logic        i_sample;

  logic [47:0] recs [0:MAX_REC-1]; // test, op, addr, data, ctrl, expected
  int          n_rec;
  int          errors;
  int          checks;
  int          test_errors;
  int          test_checks;
  logic [7:0]  cur_test;
  logic        stall_en;
  logic        stall_now;
  logic [31:0] rnd_q;

  bp_top u_dut (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_bp_data  (i_bp_data),
    .i_bp_valid (i_bp_valid),
    .o_bp_ready (o_bp_ready),
    .o_bp_data  (o_bp_data),
    .o_bp_valid (o_bp_valid),
    .i_bp_ready (i_bp_ready),
    .i_sample   (i_sample)
  );

  initial i_clk = 1'b0;
  always #4 i_clk = ~i_clk;

  function automatic logic [31:0] next_random(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Sink stalls with the enable picked up half a cycle ahead
  always begin
    @(negedge i_clk);
    stall_now = stall_en;
    @(posedge i_clk);
    #1;
    rnd_q      = next_random(rnd_q);
    i_bp_ready = stall_now ? (rnd_q[1:0] != 2'b00) : 1'b1; // Ready 3 of 4 cycles
  end

  task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
    checks++;
    test_checks++;
    assert (got === exp) else begin
      errors++;
      test_errors++;
      $display("MISMATCH at %0t ns: %s returned %02h, expected %02h", $time, what, got, exp);
    end
  endtask

  // No response is pending while a byte is offered, so ready follows the sink
  task automatic verify_ready();
    checks++;
    test_checks++;
    assert (o_bp_ready === i_bp_ready) else begin
      errors++;
      test_errors++;
      $display("MISMATCH at %0t ns: o_bp_ready is %b while i_bp_ready is %b",
               $time, o_bp_ready, i_bp_ready);
    end
  endtask

  // Every task starts and ends 1 ns after a rising edge
  task automatic send_byte(input logic [7:0] b);
    logic acc;
    i_bp_data  = b;
    i_bp_valid = 1'b1;
    acc = 1'b0;
    while (!acc) begin
      @(negedge i_clk);
      acc = o_bp_ready; // Taken on the next edge
      verify_ready();
      @(posedge i_clk);
      #1;
    end
    i_bp_valid = 1'b0;
  endtask

  task automatic recv_byte(output logic [7:0] b);
    logic got;
    got = 1'b0;
    while (!got) begin
      @(negedge i_clk);
      got = o_bp_valid && i_bp_ready;
      b   = o_bp_data;
      @(posedge i_clk);
      #1;
    end
  endtask

  // Burst length write followed by n+1 bytes drained from address 0
  task automatic run_burst(input logic [7:0] n, input logic [7:0] exp, input logic compare);
    logic [7:0] b;
    send_byte(8'h80);
    send_byte(n);
    recv_byte(b);
    check_byte(b, n, "burst length echo");
    send_byte(8'h00);
    for (int k = 0; k <= n; k++) begin
      recv_byte(b);
      if (compare) begin
        check_byte(b, exp, $sformatf("burst byte %0d", k));
      end
    end
    repeat (4) begin
      @(negedge i_clk);
      checks++;
      test_checks++;
      assert (!o_bp_valid) else begin
        errors++;
        test_errors++;
        $display("Burst of %0d bytes sent an extra byte at %0t ns", n + 1, $time);
      end
    end
    @(posedge i_clk);
    #1;
  endtask

  // New settings reach the FIFO only after the stale bytes are gone
  task automatic settle(input int gap);
    repeat (gap) @(posedge i_clk);
    #1;
    run_burst(8'(FLUSH_LEN), 8'h00, 1'b0);
    repeat (gap) @(posedge i_clk);
    #1;
  endtask

  task automatic end_test();
    $display("Test %0d finished: %0d checks, %0d errors", cur_test, test_checks, test_errors);
    test_checks = 0;
    test_errors = 0;
  endtask

  initial begin : main
    logic [47:0] r;
    logic [7:0]  b;
    int          cnt;
    i_rst_n    = 1'b0;
    i_bp_data  = 8'h00;
    i_bp_valid = 1'b0;
    i_bp_ready = 1'b1;
    i_sample   = 1'b0;
    stall_en   = 1'b0;
    rnd_q      = 32'hd773;
    errors     = 0;
    checks     = 0;
    test_errors = 0;
    test_checks = 0;
    $readmemh("bench/bp_testdata.hex", recs);
    cnt = 0;
    while ((cnt < MAX_REC) && (recs[cnt][39:32] !== 8'hff)) begin
      cnt++;
    end
    n_rec = cnt; // Starts the watchdog
    if (n_rec == 0) begin
      errors++;
      $display("The test data file holds no records");
    end
    repeat (2) @(posedge i_clk);
    #1;
    i_rst_n  = 1'b1;
    cur_test = recs[0][47:40];
    for (int i = 0; i < n_rec; i++) begin
      r = recs[i];
      if (r[47:40] != cur_test) begin
        end_test();
        cur_test = r[47:40];
      end
      i_sample = r[8];
      stall_en = r[9];
      case (r[39:32])
        8'h01: begin
          send_byte({1'b1, r[30:24]});
          send_byte(r[23:16]);
          recv_byte(b);
          check_byte(b, r[7:0], $sformatf("write echo of address %0d", r[30:24]));
        end
        8'h02: begin
          send_byte({1'b0, r[30:24]});
          recv_byte(b);
          check_byte(b, r[7:0], $sformatf("read of address %0d", r[30:24]));
        end
        8'h03: run_burst(r[23:16], r[7:0], 1'b1);
        8'h04: settle(int'(r[23:16]) * 8);
        default: begin
          errors++;
          test_errors++;
          $display("Record %0d holds an unknown operation %02h", i, r[39:32]);
        end
      endcase
    end
    end_test();
    $display("Done: %0d records, %0d checks, %0d errors", n_rec, checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  initial begin : watchdog
    wait (n_rec > 0);
    repeat (n_rec * REC_CYCLES) @(posedge i_clk);
    $display("Timeout: the tests did not complete within %0d clock cycles", n_rec * REC_CYCLES);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* bench/bp_testdata.hex */
// Columns: test, op, address, data, control, expected (one byte each)
// Ops 01 write, 02 read, 03 burst of data+1 bytes, 04 settle data*8 cycles, ff end
// Control bit 0 drives i_sample, bit 1 turns on random i_bp_ready stalls
010201000014
010205000014
01020600000F
01020700000E
010209000000
01020A000000
01020B000000
01020C000000
01020D000000
0201092A000A
02010A030001
02010BF70007
02010CFE0000
02010D350005
02020B000007
02020D000005
02010E550000
02027F000000
020101330014
030109030203
03020A000201
03010DEE020E
030209000203
030300030200
03020D00020E
060109020002
06010A010001
06010B000000
060400200000
060300070000
060300000000
04010A000100
040400200100
0403000901FF
040400200000
040300090000
05010C010101
05010D030103
050400400100
0503000901FF
050400400000
050300090000
00FF00000000

/* logic/bp_defs.svh */
`ifndef BP_DEFS_SVH
`define BP_DEFS_SVH

`default_nettype none

// Averager fraction width, also readable by the host
`define BP_PRECISION 20

// Window exponent tops out at the fraction width for the log-drop filter
`define BP_MAX_WINDOW_LENGTH_EXP `BP_PRECISION
`define BP_MAX_SAMPLE_RATE_NEGEXP 15
`define BP_MAX_SAMPLE_JITTER_NEGEXP 14

`define BP_FIFO_DEPTH 16 // Sample bytes

// BytePipe address map
`define BP_ADDR_PKTFIFO 0 // Burst port
`define BP_ADDR_PRECISION 1
`define BP_ADDR_MAX_WINDOW_LENGTH_EXP 5
`define BP_ADDR_MAX_SAMPLE_RATE_NEGEXP 6
`define BP_ADDR_MAX_SAMPLE_JITTER_NEGEXP 7
`define BP_ADDR_WINDOW_LENGTH_EXP 9
`define BP_ADDR_WINDOW_SHAPE 10
`define BP_ADDR_SAMPLE_RATE_NEGEXP 11
`define BP_ADDR_SAMPLE_MODE 12
`define BP_ADDR_SAMPLE_JITTER_NEGEXP 13
`define BP_ADDR_REG_HI 13 // Last mapped address

`default_nettype wire

`endif

/* logic/bp_pkg.sv */
`default_nettype none

package bp_pkg;

  // Averaging method of the sampling engine
  typedef enum logic {
    WIN_RECTANGULAR = 1'b0,
    WIN_LOGDROP     = 1'b1
  } window_shape_e;

  // Strobe spacing
  typedef enum logic {
    MODE_PERIODIC    = 1'b0,
    MODE_NONPERIODIC = 1'b1 // Extra pseudo-random delay
  } sample_mode_e;

  // BytePipe transaction FSM
  typedef enum logic [1:0] {
    ST_CMD   = 2'd0, // Waiting for a command byte
    ST_WRITE = 2'd1, // Waiting for the data byte
    ST_READ  = 2'd2  // Response byte(s) going out
  } bp_state_e;

  // Sampler FSM
  typedef enum logic [1:0] {
    SMP_WAIT = 2'd0,
    SMP_TAKE = 2'd1,
    SMP_EMIT = 2'd2
  } smp_state_e;

endpackage

`default_nettype wire

/* logic/bp_reg.sv */
`timescale 1ns/10ps
`include "bp_defs.svh"
`default_nettype none

// Command decoder and register map behind the BytePipe link.
// Writes echo the new read-back value and reads of address 0 drain the FIFO.
module bp_reg (
  input  wire                    i_clk,
  input  wire                    i_rst_n,

  input  wire [7:0]              i_bp_data,
  input  wire                    i_bp_valid,
  output logic                   o_bp_ready,

  output logic [7:0]             o_bp_data,
  output logic                   o_bp_valid,
  input  wire                    i_bp_ready,

  input  wire [7:0]              i_pktfifo_data,
  input  wire                    i_pktfifo_empty,
  output logic                   o_pktfifo_pop,

  output logic [4:0]             o_reg_window_length_exp,
  output bp_pkg::window_shape_e  o_reg_window_shape,
  output logic [3:0]             o_reg_sample_rate_negexp,
  output bp_pkg::sample_mode_e   o_reg_sample_mode,
  output logic [3:0]             o_reg_sample_jitter_negexp
);

  bp_pkg::bp_state_e state_q;
  logic [6:0] addr_q;
  logic       fifo_rd_q;  // Burst port read in progress
  logic [7:0] burst_q;
  logic [7:0] burst_d;
  logic [7:0] rd_data_q;
  logic       valid_q;

  logic       in_acc;
  logic       out_acc;
  logic       cmd_rd;
  logic       do_write;
  logic       burst_init;
  logic       burst_dec;
  logic       wr_wle;
  logic       wr_shape;
  logic       wr_rate;
  logic       wr_mode;
  logic       wr_jitter;

  logic [4:0]            wle_nxt;
  bp_pkg::window_shape_e shape_nxt;
  logic [3:0]            rate_nxt;
  bp_pkg::sample_mode_e  mode_nxt;
  logic [3:0]            jitter_nxt;

  logic [6:0] mux_addr;
  logic [7:0] mux_data;

  assign in_acc  = i_bp_valid && o_bp_ready;
  assign out_acc = o_bp_valid && i_bp_ready;

  assign cmd_rd   = (state_q == bp_pkg::ST_CMD) && in_acc && !i_bp_data[7];
  assign do_write = (state_q == bp_pkg::ST_WRITE) && in_acc;

  // Addresses above the map match none of these write enables
  assign burst_init = do_write && (addr_q == 7'(`BP_ADDR_PKTFIFO));
  assign wr_wle     = do_write && (addr_q == 7'(`BP_ADDR_WINDOW_LENGTH_EXP));
  assign wr_shape   = do_write && (addr_q == 7'(`BP_ADDR_WINDOW_SHAPE));
  assign wr_rate    = do_write && (addr_q == 7'(`BP_ADDR_SAMPLE_RATE_NEGEXP));
  assign wr_mode    = do_write && (addr_q == 7'(`BP_ADDR_SAMPLE_MODE));
  assign wr_jitter  = do_write && (addr_q == 7'(`BP_ADDR_SAMPLE_JITTER_NEGEXP));

  assign burst_dec = fifo_rd_q && out_acc && (burst_q != 8'd0);

  always_comb begin
    if (burst_init) begin
      burst_d = i_bp_data;
    end else if (burst_dec) begin
      burst_d = burst_q - 8'd1;
    end else begin
      burst_d = burst_q;
    end
  end

  // Post-write values so the echo shows what the register now holds
  always_comb begin
    wle_nxt    = wr_wle    ? i_bp_data[4:0] : o_reg_window_length_exp;
    shape_nxt  = wr_shape  ? bp_pkg::window_shape_e'(i_bp_data[0]) : o_reg_window_shape;
    rate_nxt   = wr_rate   ? i_bp_data[3:0] : o_reg_sample_rate_negexp;
    mode_nxt   = wr_mode   ? bp_pkg::sample_mode_e'(i_bp_data[0]) : o_reg_sample_mode;
    jitter_nxt = wr_jitter ? i_bp_data[3:0] : o_reg_sample_jitter_negexp;
  end

  assign mux_addr = (state_q == bp_pkg::ST_CMD) ? i_bp_data[6:0] : addr_q;

  always_comb begin
    case (mux_addr)
      7'(`BP_ADDR_PKTFIFO):                  mux_data = burst_d; // Echo of burst length
      7'(`BP_ADDR_PRECISION):                mux_data = 8'(`BP_PRECISION);
      7'(`BP_ADDR_MAX_WINDOW_LENGTH_EXP):    mux_data = 8'(`BP_MAX_WINDOW_LENGTH_EXP);
      7'(`BP_ADDR_MAX_SAMPLE_RATE_NEGEXP):   mux_data = 8'(`BP_MAX_SAMPLE_RATE_NEGEXP);
      7'(`BP_ADDR_MAX_SAMPLE_JITTER_NEGEXP): mux_data = 8'(`BP_MAX_SAMPLE_JITTER_NEGEXP);
      7'(`BP_ADDR_WINDOW_LENGTH_EXP):        mux_data = {3'b000, wle_nxt};
      7'(`BP_ADDR_WINDOW_SHAPE):             mux_data = {7'b0000000, shape_nxt};
      7'(`BP_ADDR_SAMPLE_RATE_NEGEXP):       mux_data = {4'b0000, rate_nxt};
      7'(`BP_ADDR_SAMPLE_MODE):              mux_data = {7'b0000000, mode_nxt};
      7'(`BP_ADDR_SAMPLE_JITTER_NEGEXP):     mux_data = {4'b0000, jitter_nxt};
      default:                               mux_data = 8'h00; // Holes and out of range
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_reg_window_length_exp    <= 5'd0;
      o_reg_window_shape         <= bp_pkg::WIN_RECTANGULAR;
      o_reg_sample_rate_negexp   <= 4'd0;
      o_reg_sample_mode          <= bp_pkg::MODE_PERIODIC;
      o_reg_sample_jitter_negexp <= 4'd0;
    end else begin
      o_reg_window_length_exp    <= wle_nxt;
      o_reg_window_shape         <= shape_nxt;
      o_reg_sample_rate_negexp   <= rate_nxt;
      o_reg_sample_mode          <= mode_nxt;
      o_reg_sample_jitter_negexp <= jitter_nxt;
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      state_q   <= bp_pkg::ST_CMD;
      fifo_rd_q <= 1'b0;
      valid_q   <= 1'b0;
      burst_q   <= 8'd0;
    end else begin
      burst_q <= burst_d;
      case (state_q)
        bp_pkg::ST_CMD: begin
          if (in_acc && i_bp_data[7]) begin
            state_q <= bp_pkg::ST_WRITE;
          end else if (in_acc) begin
            state_q   <= bp_pkg::ST_READ;
            fifo_rd_q <= (i_bp_data[6:0] == 7'(`BP_ADDR_PKTFIFO));
            valid_q   <= (i_bp_data[6:0] != 7'(`BP_ADDR_PKTFIFO));
          end
        end
        bp_pkg::ST_WRITE: begin
          if (in_acc) begin
            state_q <= bp_pkg::ST_READ;
            valid_q <= 1'b1; // Echo goes out next
          end
        end
        bp_pkg::ST_READ: begin
          if (o_pktfifo_pop) begin
            valid_q <= 1'b1;
          end else if (out_acc) begin
            valid_q <= 1'b0;
            // Burst ends on the byte sent with the counter at zero
            if (!fifo_rd_q || (burst_q == 8'd0)) begin
              state_q   <= bp_pkg::ST_CMD;
              fifo_rd_q <= 1'b0;
            end
          end
        end
        default: state_q <= bp_pkg::ST_CMD;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if ((state_q == bp_pkg::ST_CMD) && in_acc) begin
      addr_q <= i_bp_data[6:0];
    end
    if (cmd_rd || do_write) begin
      rd_data_q <= mux_data;
    end else if (o_pktfifo_pop) begin
      rd_data_q <= i_pktfifo_data;
    end
  end

  // One FIFO byte at a time and only while the output slot is free
  assign o_pktfifo_pop = (state_q == bp_pkg::ST_READ) && fifo_rd_q && !valid_q &&
                         !i_pktfifo_empty;

  // Sink back-pressure passes straight through and no new command is taken while responding
  assign o_bp_ready = i_bp_ready && (state_q != bp_pkg::ST_READ);
  assign o_bp_data  = rd_data_q;
  assign o_bp_valid = valid_q;

  // A response only exists once its command is complete
  a_valid_in_read: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_bp_valid |-> (state_q == bp_pkg::ST_READ));

  a_out_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (o_bp_valid && !i_bp_ready) |=> (o_bp_valid && $stable(o_bp_data)));

endmodule

`default_nettype wire

/* logic/bp_top.sv */
`timescale 1ns/10ps
`default_nettype none

// Register access subsystem with BytePipe decoder, sample FIFO and sampler
module bp_top (
  input  wire       i_clk,
  input  wire       i_rst_n,

  input  wire [7:0] i_bp_data,
  input  wire       i_bp_valid,
  output wire       o_bp_ready,

  output wire [7:0] o_bp_data,
  output wire       o_bp_valid,
  input  wire       i_bp_ready,

  input  wire       i_sample
);

  logic [7:0]            fifo_data;
  logic                  fifo_empty;
  logic                  fifo_pop;
  logic                  fifo_full;
  logic                  smp_push;
  logic [7:0]            smp_push_data;

  // Configuration from the register map
  logic [4:0]            reg_window_length_exp;
  bp_pkg::window_shape_e reg_window_shape;
  logic [3:0]            reg_sample_rate_negexp;
  bp_pkg::sample_mode_e  reg_sample_mode;
  logic [3:0]            reg_sample_jitter_negexp;

  bp_reg u_reg (
    .i_clk                      (i_clk),
    .i_rst_n                    (i_rst_n),
    .i_bp_data                  (i_bp_data),
    .i_bp_valid                 (i_bp_valid),
    .o_bp_ready                 (o_bp_ready),
    .o_bp_data                  (o_bp_data),
    .o_bp_valid                 (o_bp_valid),
    .i_bp_ready                 (i_bp_ready),
    .i_pktfifo_data             (fifo_data),
    .i_pktfifo_empty            (fifo_empty),
    .o_pktfifo_pop              (fifo_pop),
    .o_reg_window_length_exp    (reg_window_length_exp),
    .o_reg_window_shape         (reg_window_shape),
    .o_reg_sample_rate_negexp   (reg_sample_rate_negexp),
    .o_reg_sample_mode          (reg_sample_mode),
    .o_reg_sample_jitter_negexp (reg_sample_jitter_negexp)
  );

  pkt_fifo u_fifo (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_push      (smp_push),
    .i_push_data (smp_push_data),
    .o_full      (fifo_full),
    .i_pop       (fifo_pop),
    .o_data      (fifo_data),
    .o_empty     (fifo_empty)
  );

  sample_engine u_smp (
    .i_clk                  (i_clk),
    .i_rst_n                (i_rst_n),
    .i_sample               (i_sample),
    .i_window_length_exp    (reg_window_length_exp),
    .i_window_shape         (reg_window_shape),
    .i_sample_rate_negexp   (reg_sample_rate_negexp),
    .i_sample_mode          (reg_sample_mode),
    .i_sample_jitter_negexp (reg_sample_jitter_negexp),
    .i_full                 (fifo_full),
    .o_push                 (smp_push),
    .o_push_data            (smp_push_data)
  );

endmodule

`default_nettype wire

/* logic/pkt_fifo.sv */
`timescale 1ns/10ps
`include "bp_defs.svh"
`default_nettype none

// Byte FIFO between the sampling engine and the register block
module pkt_fifo (
  input  wire        i_clk,
  input  wire        i_rst_n,

  input  wire        i_push,
  input  wire [7:0]  i_push_data,
  output logic       o_full,

  input  wire        i_pop,
  output logic [7:0] o_data,
  output logic       o_empty
);

  localparam int DEPTH = `BP_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);

  logic [7:0]       mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W:0]   count_q; // One bit wider to hold DEPTH
  logic             push_ok;
  logic             pop_ok;

  assign push_ok = i_push && !o_full;
  assign pop_ok  = i_pop && !o_empty;

  assign o_full  = (count_q == (PTR_W+1)'(DEPTH));
  assign o_empty = (count_q == '0);
  assign o_data  = mem_q[rd_ptr_q]; // Head of queue with no read latency

  always_ff @(posedge i_clk) begin
    if (push_ok) begin
      mem_q[wr_ptr_q] <= i_push_data;
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push_ok, pop_ok})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q; // Both or neither
      endcase
    end
  end

  // The engine has to drop its result itself when the queue is full
  a_no_push_full: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_push |-> !o_full);

endmodule

`default_nettype wire

/* logic/sample_engine.sv */
`timescale 1ns/10ps
`include "bp_defs.svh"
`default_nettype none

// Samples a one-bit input on a strobe and averages it over a window.
// Each finished window produces the top byte of the average.
module sample_engine (
  input  wire                       i_clk,
  input  wire                       i_rst_n,
  input  wire                       i_sample,

  input  wire [4:0]                 i_window_length_exp,
  input  var bp_pkg::window_shape_e i_window_shape,
  input  wire [3:0]                 i_sample_rate_negexp,
  input  var bp_pkg::sample_mode_e  i_sample_mode,
  input  wire [3:0]                 i_sample_jitter_negexp,

  input  wire                       i_full,
  output logic                      o_push,
  output logic [7:0]                o_push_data
);

  localparam int PREC = `BP_PRECISION;
  localparam logic [PREC-1:0] ONES = '1;

  bp_pkg::smp_state_e state_q;
  logic [1:0]      sync_q;  // Input synchronizer
  logic            smp_q;
  logic [15:0]     lfsr_q;
  logic [15:0]     jitter;
  logic [15:0]     reload;
  logic [15:0]     strobe_cnt_q;
  logic            strobe;
  logic [4:0]      win;
  logic [PREC:0]   win_mask;
  logic [PREC-1:0] win_cnt_q;
  logic            win_done;
  logic [PREC:0]   sum_q;
  logic [PREC:0]   sum_nxt;
  logic [PREC:0]   rect_frac;
  logic [PREC-1:0] rect_val;
  logic [PREC-1:0] ld_q;
  logic [PREC-1:0] ld_nxt;

  // Exponents past the fraction width add nothing
  assign win      = (i_window_length_exp > 5'(PREC)) ? 5'(PREC) : i_window_length_exp;
  assign win_mask = ((PREC+1)'(1) << win) - 1'b1;
  assign win_done = (win_cnt_q >= win_mask[PREC-1:0]);

  assign jitter = (i_sample_mode == bp_pkg::MODE_NONPERIODIC) ?
                  (lfsr_q & ((16'd1 << i_sample_jitter_negexp) - 16'd1)) : 16'd0;
  assign reload = ((16'd1 << i_sample_rate_negexp) - 16'd1) + jitter;

  // Counter only runs while idle so no strobe lands during an update
  assign strobe = (state_q == bp_pkg::SMP_WAIT) && (strobe_cnt_q == 16'd0);

  assign sum_nxt   = sum_q + (PREC+1)'(smp_q);
  assign rect_frac = sum_nxt << (5'(PREC) - win);
  assign rect_val  = rect_frac[PREC] ? ONES : rect_frac[PREC-1:0]; // All ones saturates

  // Step toward the sample by the remaining distance over 2^win
  assign ld_nxt = smp_q ? ld_q + ((ONES - ld_q) >> win) : ld_q - (ld_q >> win);

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      lfsr_q       <= 16'hace1;
      strobe_cnt_q <= 16'd0;
    end else begin
      // Galois form with taps 16 14 13 11
      lfsr_q <= {1'b0, lfsr_q[15:1]} ^ (lfsr_q[0] ? 16'hb400 : 16'h0000);
      if (state_q == bp_pkg::SMP_WAIT) begin
        strobe_cnt_q <= strobe ? reload : strobe_cnt_q - 16'd1;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      state_q   <= bp_pkg::SMP_WAIT;
      win_cnt_q <= '0;
      sum_q     <= '0;
      ld_q      <= '0;
    end else begin
      case (state_q)
        bp_pkg::SMP_WAIT: begin
          if (strobe) state_q <= bp_pkg::SMP_TAKE;
        end
        bp_pkg::SMP_TAKE: begin
          win_cnt_q <= win_done ? '0 : win_cnt_q + 1'b1;
          if (i_window_shape == bp_pkg::WIN_RECTANGULAR) begin
            sum_q <= win_done ? '0 : sum_nxt;
          end else begin
            sum_q <= '0;
            ld_q  <= ld_nxt;
          end
          state_q <= win_done ? bp_pkg::SMP_EMIT : bp_pkg::SMP_WAIT;
        end
        bp_pkg::SMP_EMIT: state_q <= bp_pkg::SMP_WAIT; // Result dropped if FIFO full
        default:          state_q <= bp_pkg::SMP_WAIT;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    sync_q <= {sync_q[0], i_sample};
    if (strobe) begin
      smp_q <= sync_q[1];
    end
    if ((state_q == bp_pkg::SMP_TAKE) && win_done) begin
      o_push_data <= (i_window_shape == bp_pkg::WIN_RECTANGULAR) ?
                     rect_val[PREC-1 -: 8] : ld_nxt[PREC-1 -: 8];
    end
  end

  assign o_push = (state_q == bp_pkg::SMP_EMIT) && !i_full;

endmodule

`default_nettype wire

/* verilog.f */
+incdir+logic
logic/bp_pkg.sv
logic/pkt_fifo.sv
logic/sample_engine.sv
logic/bp_reg.sv
logic/bp_top.sv
bench/bp_tb.sv
